// File: source/dot_pkg.sv
package dot_pkg;

    // default lane count, top level must match it
    parameter int LANES_DEF      = 8;
    // weight fifo depth in slots
    parameter int FIFO_DEPTH_DEF = 8;

    // byte width of weights and activations
    parameter int W_W   = 8;
    // per lane accumulator
    parameter int ACC_W = 24;
    // reduced result width
    parameter int RES_W = 32;
    // vectors per job
    parameter int CNT_W = 8;

    // one weight vector, lane 0 in the low byte
    typedef struct packed {
        logic signed [LANES_DEF-1:0][W_W-1:0] b;
    } weight_vec_t;

    // activations, same shape as the weights
    typedef struct packed {
        logic signed [LANES_DEF-1:0][W_W-1:0] b;
    } act_vec_t;

    // fifo slot with its valid bit
    typedef struct packed {
        logic        valid;
        weight_vec_t data;
    } slot_t;

endpackage

// File: source/weight_fifo.sv
`timescale 1ns/100ps

module weight_fifo import dot_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH_DEF
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        write_en_i,
    input  logic        sending_data_i,
    input  logic        read_en_i,
    input  weight_vec_t data_i,
    output logic        request_data_o,
    output logic        valid_o,
    output weight_vec_t data_o
);

    // slot 0 is the head, DEPTH-1 the tail
    slot_t [DEPTH-1:0] slots;

    logic             full;
    logic             shift;
    logic             capture;
    // valid bit of every slot, occupancy view of the chain
    logic [DEPTH-1:0] slot_valid;

    // valid head that nobody reads blocks the whole chain
    always_comb begin
        full           = slots[0].valid & ~read_en_i;
        shift          = ~full;
        request_data_o = write_en_i & ~full;
        // word qualified by sending_data in the same cycle
        capture        = write_en_i & sending_data_i & ~full;
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_valid[i] = slots[i].valid;
        end
    end

    // shift chain
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // only the valid bits are cleared, payload is don't care
            for (int i = 0; i < DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else if (shift) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                slots[i] <= slots[i+1];
            end
            // new word or a bubble at the tail
            if (capture) begin
                slots[DEPTH-1].valid <= 1'b1;
                slots[DEPTH-1].data  <= data_i;
            end else begin
                slots[DEPTH-1].valid <= 1'b0;
            end
        end
    end

    // head register, valid is a strobe per pop
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            // no read means no output beat
            valid_o <= read_en_i & slots[0].valid;
        end
    end

    // head payload, only moves on a read
    always_ff @(posedge clk_i) begin
        if (read_en_i) begin
            data_o <= slots[0].data;
        end
    end

    // occupancy only grows by a capture at the tail and shrinks by a pop at the head
    a_no_word_lost: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $countones(slot_valid) == $past($countones(slot_valid)) + $past(int'(capture))
            - $past(int'(read_en_i & slots[0].valid))
    ) else $error("weight fifo lost or gained a word");

endmodule

// File: source/job_ctrl.sv
`timescale 1ns/100ps

module job_ctrl import dot_pkg::*; #(
    parameter int CNT_W = 8
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic [CNT_W-1:0] count_i,
    input  act_vec_t         act_i,
    input  logic             head_valid_i,
    output logic             read_en_o,
    output logic             clear_o,
    output logic             reduce_o,
    output logic             busy_o,
    output act_vec_t         act_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_REDUCE
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] remaining_q;
    logic             clear_q;
    logic             last_vec;

    // count-th vector is on the fifo output right now
    assign last_vec = (state_q == S_RUN) && head_valid_i && (remaining_q == CNT_W'(1));

    // stop reading once the last pop is visible, else one word too many
    assign read_en_o = (state_q == S_RUN) && (remaining_q != '0) && !last_vec;
    assign clear_o   = clear_q;
    assign reduce_o  = (state_q == S_REDUCE);
    assign busy_o    = (state_q != S_IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= S_IDLE;
            remaining_q <= '0;
            clear_q     <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    // start while busy never gets here
                    if (start_i) begin
                        state_q     <= S_RUN;
                        remaining_q <= count_i;
                        clear_q     <= 1'b1;
                    end
                end
                S_RUN: begin
                    // zero count drops straight through to reduce
                    if (remaining_q == '0 || last_vec) begin
                        state_q <= S_REDUCE;
                    end else if (head_valid_i) begin
                        remaining_q <= remaining_q - CNT_W'(1);
                    end
                end
                S_REDUCE: state_q <= S_IDLE;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    // activation vector held for the whole job
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && start_i) begin
            act_o <= act_i;
        end
    end

    a_clear_reduce_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(clear_o && reduce_o)
    ) else $error("clear and reduce together");

    // fifo beats only ever land inside a running job
    a_beat_in_run: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        head_valid_i |-> (state_q == S_RUN)
    ) else $error("fifo beat outside run state");

endmodule

// File: source/mac_lane.sv
`timescale 1ns/100ps

module mac_lane import dot_pkg::*; #(
    parameter int ACC_W = 24
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clear_i,
    input  logic                    acc_en_i,
    input  logic signed [W_W-1:0]   weight_i,
    input  logic signed [W_W-1:0]   act_i,
    output logic signed [ACC_W-1:0] acc_o
);

    // full precision byte product
    logic signed [2*W_W-1:0] prod;
    logic signed [ACC_W-1:0] prod_ext;

    always_comb begin
        // both bytes widened to product width first
        prod     = (2*W_W)'(weight_i) * (2*W_W)'(act_i);
        // sign extend into accumulator width
        prod_ext = {{(ACC_W-2*W_W){prod[2*W_W-1]}}, prod};
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_o <= '0;
        end else if (clear_i) begin
            // new job, clear wins over a beat
            acc_o <= '0;
        end else if (acc_en_i) begin
            acc_o <= acc_o + prod_ext;
        end
    end

endmodule

// File: source/lane_reducer.sv
`timescale 1ns/100ps

module lane_reducer #(
    parameter int LANES = 8,
    parameter int ACC_W = 24,
    parameter int RES_W = 32
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    reduce_i,
    input  logic signed [ACC_W-1:0] acc_i [LANES],
    output logic signed [RES_W-1:0] result_o,
    output logic                    result_valid_o
);

    // tree levels, leaves padded up to a power of two
    localparam int LEVELS = $clog2(LANES);
    localparam int LEAVES = 1 << LEVELS;

    logic signed [RES_W-1:0] tree [LEVELS+1][LEAVES];

    always_comb begin
        // padding leaves stay zero
        tree = '{default: '0};
        for (int k = 0; k < LANES; k++) begin
            tree[0][k] = {{(RES_W-ACC_W){acc_i[k][ACC_W-1]}}, acc_i[k]};
        end
        // pairwise sums, one level at a time
        for (int l = 1; l <= LEVELS; l++) begin
            for (int n = 0; n < (LEAVES >> l); n++) begin
                tree[l][n] = tree[l-1][2*n] + tree[l-1][2*n+1];
            end
        end
    end

    // sum captured on reduce, held until the next job
    always_ff @(posedge clk_i) begin
        if (reduce_i) begin
            result_o <= tree[LEVELS][0];
        end
    end

    // one cycle strobe after reduce
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= reduce_i;
        end
    end

endmodule

// File: source/dot_engine_top.sv
`timescale 1ns/100ps

module dot_engine_top import dot_pkg::*; #(
    parameter int LANES      = LANES_DEF,
    parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    write_en_i,
    input  logic                    sending_data_i,
    input  weight_vec_t             weight_i,
    output logic                    request_data_o,
    input  logic                    start_i,
    input  logic [CNT_W-1:0]        count_i,
    input  act_vec_t                act_i,
    output logic                    busy_o,
    output logic signed [RES_W-1:0] result_o,
    output logic                    result_valid_o
);

    // vector structs are sized by the package default
    if (LANES != LANES_DEF) begin : g_lanes_check
        $error("LANES must equal LANES_DEF");
    end

    weight_vec_t             fifo_data;
    logic                    fifo_valid;
    logic                    read_en;
    logic                    clear;
    logic                    reduce;
    act_vec_t                act_q;
    logic signed [ACC_W-1:0] lane_acc [LANES];

    weight_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .write_en_i     (write_en_i),
        .sending_data_i (sending_data_i),
        .read_en_i      (read_en),
        .data_i         (weight_i),
        .request_data_o (request_data_o),
        .valid_o        (fifo_valid),
        .data_o         (fifo_data)
    );

    job_ctrl #(.CNT_W(CNT_W)) u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (start_i),
        .count_i      (count_i),
        .act_i        (act_i),
        .head_valid_i (fifo_valid),
        .read_en_o    (read_en),
        .clear_o      (clear),
        .reduce_o     (reduce),
        .busy_o       (busy_o),
        .act_o        (act_q)
    );

    // one byte of each vector per lane, fifo beat is the enable
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        mac_lane #(.ACC_W(ACC_W)) u_lane (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .clear_i  (clear),
            .acc_en_i (fifo_valid),
            .weight_i (fifo_data.b[g]),
            .act_i    (act_q.b[g]),
            .acc_o    (lane_acc[g])
        );
    end

    lane_reducer #(.LANES(LANES), .ACC_W(ACC_W), .RES_W(RES_W)) u_reduce (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .reduce_i       (reduce),
        .acc_i          (lane_acc),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

endmodule

// File: bench/tb_dot_engine.sv
`timescale 1ns/100ps

module tb_dot_engine import dot_pkg::*; ();

    // 42 vectors over all jobs, 40 cycles each plus reset and slack
    localparam int TIMEOUT_CYCLES = 40 * 42 + 200;

    logic                    clk_i = 1'b0;
    logic                    rst_n_i;
    logic                    write_en_i;
    logic                    sending_data_i;
    weight_vec_t             weight_i;
    logic                    request_data_o;
    logic                    start_i;
    logic [CNT_W-1:0]        count_i;
    act_vec_t                act_i;
    logic                    busy_o;
    logic signed [RES_W-1:0] result_o;
    logic                    result_valid_o;

    // weight memory model state
    weight_vec_t             weight_q [$];
    logic                    took_word = 1'b0;
    logic                    bursty = 1'b0;
    int                      accepted_cnt = 0;
    int                      cycle_cnt = 0;

    dot_engine_top UUT (.*);

    always #5 clk_i = ~clk_i;

    // hard limit on the run length
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: no result arrived within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // fifo takes the word when the source writes, sends and the fifo asks
    always @(negedge clk_i) begin
        took_word = write_en_i & sending_data_i & request_data_o;
    end

    // source side, one word leaves the queue per accepted beat
    always @(posedge clk_i) begin
        #1;
        if (took_word) begin
            void'(weight_q.pop_front());
            accepted_cnt++;
        end
        write_en_i     = (weight_q.size() != 0);
        // bursty source holds sending_data low about one cycle in three
        sending_data_i = write_en_i & (!bursty | ($urandom_range(2, 0) != 0));
        if (write_en_i) begin
            weight_i = weight_q[0];
        end
    end

    task automatic check_value(input longint expected, input longint actual, input string what);
        if (expected != actual) begin
            $display("[ERROR] %0t: %s, expected %0d, got %0d",
                     $time, what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // queue n weight vectors, sum of act[i] * w[i] over all of them
    task automatic push_vecs(input act_vec_t a, input int n, input logic rnd,
                             input logic [W_W-1:0] fill, inout longint sum);
        weight_vec_t w;
        for (int k = 0; k < n; k++) begin
            w = rnd ? weight_vec_t'({$urandom, $urandom}) : weight_vec_t'({LANES_DEF{fill}});
            for (int i = 0; i < LANES_DEF; i++) begin
                sum += longint'($signed(a.b[i])) * longint'($signed(w.b[i]));
            end
            weight_q.push_back(w);
        end
    endtask

    // one cycle start strobe with its count and activations
    task automatic start_job(input act_vec_t a, input int count);
        @(posedge clk_i) #1;
        start_i = 1'b1;
        count_i = CNT_W'(count);
        act_i   = a;
        @(posedge clk_i) #1;
        start_i = 1'b0;
    endtask

    // result strobe, then its width
    task automatic wait_result(input longint expected, input string what);
        @(negedge clk_i);
        while (!result_valid_o) @(negedge clk_i);
        check_value(expected, longint'(result_o), what);
        @(negedge clk_i);
        check_value(0, longint'(result_valid_o), "result valid wider than one cycle");
    endtask

    task automatic run_job(input act_vec_t a, input int n, input logic rnd,
                           input logic [W_W-1:0] fill, input string what);
        longint sum;
        sum = 0;
        push_vecs(a, n, rnd, fill, sum);
        start_job(a, n);
        wait_result(sum, what);
    endtask

    // idle engine, so the chain freezes once the head is valid
    task automatic back_pressure_fill();
        act_vec_t a;
        longint   sum;
        a            = act_vec_t'({$urandom, $urandom});
        sum          = 0;
        accepted_cnt = 0;
        push_vecs(a, 12, 1'b1, '0, sum);
        @(negedge clk_i);
        while (accepted_cnt == 0 || request_data_o) @(negedge clk_i);
        check_value(longint'(FIFO_DEPTH_DEF), longint'(accepted_cnt), "words in full fifo");
        repeat (5) @(negedge clk_i);
        check_value(0, longint'(request_data_o), "request while fifo full");
        check_value(longint'(FIFO_DEPTH_DEF), longint'(accepted_cnt), "words taken while full");
        start_job(a, 12);
        wait_result(sum, "back pressure job");
    endtask

    task automatic back_to_back_jobs();
        act_vec_t a1;
        act_vec_t a2;
        longint   sum1;
        longint   sum2;
        a1   = act_vec_t'({$urandom, $urandom});
        a2   = act_vec_t'({$urandom, $urandom});
        sum1 = 0;
        sum2 = 0;
        // both jobs sit in the fifo in order
        push_vecs(a1, 3, 1'b1, '0, sum1);
        push_vecs(a2, 5, 1'b1, '0, sum2);
        start_job(a1, 3);
        check_value(1, longint'(busy_o), "busy during first job");
        // dropped, first job keeps its own count and activations
        start_job(a2, 5);
        wait_result(sum1, "first of two jobs");
        start_job(a2, 5);
        wait_result(sum2, "second of two jobs");
    endtask

    initial begin
        void'($urandom(80));
        rst_n_i        = 1'b0;
        write_en_i     = 1'b0;
        sending_data_i = 1'b0;
        weight_i       = '0;
        start_i        = 1'b0;
        count_i        = '0;
        act_i          = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        run_job(act_vec_t'({$urandom, $urandom}), 4, 1'b1, '0, "single random job");
        // extremes, 4 vectors of 8 lanes at 16384 stay well inside the accumulators
        run_job(act_vec_t'({LANES_DEF{8'h80}}), 4, 1'b0, 8'h80, "all -128 times -128");
        run_job(act_vec_t'({LANES_DEF{8'h80}}), 4, 1'b0, 8'h7f, "all 127 times -128");
        back_pressure_fill();
        back_to_back_jobs();
        run_job(act_vec_t'({$urandom, $urandom}), 0, 1'b1, '0, "zero count job");
        check_value(0, longint'(busy_o), "busy after zero count job");
        bursty = 1'b1;
        run_job(act_vec_t'({$urandom, $urandom}), 10, 1'b1, '0, "bursty source");
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: sources.f
source/dot_pkg.sv
source/weight_fifo.sv
source/job_ctrl.sv
source/mac_lane.sv
source/lane_reducer.sv
source/dot_engine_top.sv
bench/tb_dot_engine.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the dot engine testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_dot_engine
./obj_dir/Vtb_dot_engine > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
